// ==== common/zx_ctl_pkg.sv ====
`default_nettype none

package zx_ctl_pkg;

    // serial data byte or register value
    typedef logic [7:0] byte_t;

    // --------------------
    // host command codes
    // --------------------
    typedef enum logic [7:0] {
        cmd_covox       = 8'h53,
        cmd_int_control = 8'h54,
        cmd_scr_mode    = 8'haf
    } cmd_e;

    // link state, follows the chip-select level
    typedef enum logic [1:0] {
        idle_cmd   = 2'd0,
        data_phase = 2'd1,
        frame_end  = 2'd2
    } link_phase_e;

    // --------------------
    // raster marks
    // --------------------
    // horizontal, in steps
    localparam logic [8:0] hsync_end_tv  = 9'd33;
    localparam logic [8:0] hsync_end_vga = 9'd53;
    localparam logic [8:0] hblank_beg    = 9'd416;
    localparam logic [8:0] hblank_end    = 9'd98;
    localparam logic [8:0] csync_cut_tv  = 9'd415;

    // vertical, in lines
    localparam logic [8:0] vblank_beg    = 9'd294;
    localparam logic [8:0] vblank_end    = 9'd44;
    localparam logic [8:0] vsync_end     = 9'd2;

    // --------------------
    // register defaults
    // --------------------
    // mid-scale sample, silent output
    localparam byte_t covox_reset = 8'h7f;

    // readback for commands with nothing to return
    localparam byte_t read_idle   = 8'hff;

endpackage

`default_nettype wire

// ==== source/spi_slave.sv ====
`default_nettype none

module spi_slave (
    input  wire                         fclk,
    input  wire                         rst_n,
    input  wire                         spick,
    input  wire                         spics_n,
    input  wire                         spido,
    input  wire zx_ctl_pkg::byte_t      rd_data,
    output logic                        spidi,
    output zx_ctl_pkg::byte_t           cmd,
    output zx_ctl_pkg::byte_t           wr_data,
    output logic                        frame_start,
    output logic                        frame_end
);

    logic [1:0]              sck_sync;
    logic [1:0]              cs_sync;
    logic [1:0]              di_sync;
    logic                    sck_q;
    logic                    cs_q;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    cs_rise;
    logic                    cs_fall;
    logic                    load_q;
    zx_ctl_pkg::byte_t       shift_out;
    zx_ctl_pkg::link_phase_e phase;

    // --------------------
    // input synchronizers
    // --------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            sck_sync <= 2'b00;
            cs_sync  <= 2'b11;
            di_sync  <= 2'b00;
            sck_q    <= 1'b0;
            cs_q     <= 1'b1;
        end
        else
        begin
            sck_sync <= {sck_sync[0], spick};
            cs_sync  <= {cs_sync[0], spics_n};
            di_sync  <= {di_sync[0], spido};
            sck_q    <= sck_sync[1];
            cs_q     <= cs_sync[1];
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_q;
    assign sck_fall = ~sck_sync[1] & sck_q;
    assign cs_rise  = cs_sync[1] & ~cs_q;
    assign cs_fall  = ~cs_sync[1] & cs_q;

    // --------------------
    // link phase FSM
    // --------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            phase <= zx_ctl_pkg::idle_cmd;
        else
        begin
            case (phase)
                zx_ctl_pkg::idle_cmd:
                    if (cs_fall)
                        phase <= zx_ctl_pkg::data_phase;
                zx_ctl_pkg::data_phase:
                    if (cs_rise)
                        phase <= zx_ctl_pkg::frame_end;
                // frame end lasts one cycle
                default:
                    phase <= zx_ctl_pkg::idle_cmd;
            endcase
        end
    end

    assign frame_start = cs_fall && (phase == zx_ctl_pkg::idle_cmd);
    assign frame_end   = (phase == zx_ctl_pkg::frame_end);

    // command byte and readback shifter
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            cmd       <= 8'hff;
            load_q    <= 1'b0;
            shift_out <= 8'hff;
        end
        else
        begin
            load_q <= frame_start;
            if (sck_rise && (phase == zx_ctl_pkg::idle_cmd))
                cmd <= {cmd[6:0], di_sync[1]};
            // rd_data is ready the cycle after frame_start
            if (load_q)
                shift_out <= rd_data;
            else if (sck_fall && (phase == zx_ctl_pkg::data_phase))
                shift_out <= {shift_out[6:0], 1'b1};
        end
    end

    // data byte, msb first
    always_ff @(posedge fclk)
    begin
        if (sck_rise && (phase == zx_ctl_pkg::data_phase))
            wr_data <= {wr_data[6:0], di_sync[1]};
    end

    assign spidi = shift_out[7];

endmodule

`default_nettype wire

// ==== source/avr_ctrl.sv ====
`default_nettype none

module avr_ctrl (
    input  wire                     fclk,
    input  wire                     rst_n,
    input  wire zx_ctl_pkg::byte_t  cmd,
    input  wire zx_ctl_pkg::byte_t  wr_data,
    input  wire                     frame_start,
    input  wire                     frame_end,
    input  wire                     covox_tick,
    input  wire                     vblank,
    output zx_ctl_pkg::byte_t       rd_data,
    output zx_ctl_pkg::byte_t       covox,
    output logic                    tv_mode,
    output logic                    spiint_n
);

    logic en_covox_int;
    logic en_frame_int;

    // --------------------
    // register writes
    // --------------------
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            covox        <= zx_ctl_pkg::covox_reset;
            tv_mode      <= 1'b1;
            en_covox_int <= 1'b0;
            en_frame_int <= 1'b0;
        end
        else if (frame_end)
        begin
            case (zx_ctl_pkg::cmd_e'(cmd))
                zx_ctl_pkg::cmd_covox:
                    covox <= wr_data;
                zx_ctl_pkg::cmd_int_control:
                begin
                    en_covox_int <= wr_data[0];
                    en_frame_int <= wr_data[1];
                end
                zx_ctl_pkg::cmd_scr_mode:
                    tv_mode <= wr_data[0];
                // unknown codes are dropped
                default:
                    ;
            endcase
        end
    end

    // --------------------
    // readback select
    // --------------------
    // latched as the data phase opens
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            rd_data <= zx_ctl_pkg::read_idle;
        else if (frame_start)
        begin
            if (cmd == zx_ctl_pkg::cmd_covox)
                rd_data <= ~covox;
            else
                rd_data <= zx_ctl_pkg::read_idle;
        end
    end

    // --------------------
    // host interrupt
    // --------------------
    // covox pulses win over frame blanking
    always_ff @(posedge fclk)
    begin
        if (!rst_n)
            spiint_n <= 1'b1;
        else if (en_covox_int)
            spiint_n <= ~covox_tick;
        else if (en_frame_int)
            spiint_n <= ~vblank;
        else
            spiint_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/covox_pwm.sv ====
`default_nettype none

module covox_pwm (
    input  wire                     fclk,
    input  wire                     rst_n,
    input  wire zx_ctl_pkg::byte_t  covox,
    output logic                    beep,
    output logic                    covox_tick
);

    logic [9:0]        phase;
    zx_ctl_pkg::byte_t sample;
    zx_ctl_pkg::byte_t level;

    // new sample already counts at phase zero
    assign level = (phase[7:0] == 8'h00) ? covox : sample;

    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            phase <= 10'd0;
            beep  <= 1'b0;
        end
        else
        begin
            phase <= phase + 10'd1;
            beep  <= (phase[7:0] < level);
        end
    end

    // sample held for a whole 256-cycle window
    always_ff @(posedge fclk)
    begin
        if (phase[7:0] == 8'h00)
            sample <= covox;
    end

    // 4 cycles out of every 1024
    assign covox_tick = (phase[9:2] == 8'h00);

endmodule

`default_nettype wire

// ==== video/video_timing.sv ====
`default_nettype none

module video_timing #(
    parameter logic [8:0] h_max = 9'd447,
    parameter logic [8:0] v_max = 9'd319
) (
    input  wire  fclk,
    input  wire  rst_n,
    input  wire  tv_mode,
    output logic hsync,
    output logic vsync,
    output logic vcsync,
    output logic vblank
);

    logic [1:0] presc;
    logic       h_step;
    logic [8:0] hcount;
    logic [8:0] h_next;
    logic [8:0] hsync_end;
    logic       hblank;
    logic       hblank_next;
    logic       line_pair;
    logic       next_line;
    logic [8:0] vcount;
    logic [8:0] v_next;
    logic       csync;

    // one step per 4 fclk in tv, per 2 in vga
    assign h_step = tv_mode ? (presc == 2'd0) : ~presc[0];

    assign h_next = (hcount == h_max) ? 9'd0 : hcount + 9'd1;
    assign v_next = (vcount == v_max) ? 9'd0 : vcount + 9'd1;

    assign hsync_end = tv_mode ? zx_ctl_pkg::hsync_end_tv : zx_ctl_pkg::hsync_end_vga;

    always_comb
    begin
        hblank_next = hblank;
        if (h_next == zx_ctl_pkg::hblank_beg)
            hblank_next = 1'b1;
        else if (h_next == zx_ctl_pkg::hblank_end)
            hblank_next = 1'b0;
    end

    always_ff @(posedge fclk)
    begin
        if (!rst_n)
        begin
            presc     <= 2'd0;
            hcount    <= 9'd0;
            hblank    <= 1'b1;
            hsync     <= 1'b1;
            line_pair <= 1'b1;
            next_line <= 1'b0;
            csync     <= 1'b1;
            vcount    <= 9'd0;
            vblank    <= 1'b1;
            vsync     <= 1'b1;
        end
        else
        begin
            presc     <= presc + 2'd1;
            next_line <= 1'b0;

            // --------------------
            // horizontal
            // --------------------
            if (h_step)
            begin
                hcount <= h_next;
                hblank <= hblank_next;

                if (h_next == 9'd0)
                begin
                    hsync     <= 1'b1;
                    // vga scans each vertical line twice
                    line_pair <= tv_mode | ~line_pair;
                    if (line_pair)
                    begin
                        csync     <= 1'b1;
                        next_line <= 1'b1;
                    end
                end

                if (h_next == hsync_end)
                begin
                    hsync <= 1'b0;
                    // csync stays up across the vsync lines
                    if (!vsync)
                        csync <= 1'b0;
                end

                // vga cut as line blanking starts
                if (!tv_mode && hblank_next && !hblank)
                    csync <= 1'b0;

                if (tv_mode && (h_next == zx_ctl_pkg::csync_cut_tv))
                    csync <= 1'b0;
            end

            // --------------------
            // vertical
            // --------------------
            if (next_line)
            begin
                vcount <= v_next;
                if (v_next == zx_ctl_pkg::vblank_beg)
                    vblank <= 1'b1;
                else if (v_next == zx_ctl_pkg::vblank_end)
                    vblank <= 1'b0;
                vsync <= (v_next < zx_ctl_pkg::vsync_end);
            end
        end
    end

    assign vcsync = ~csync;

endmodule

`default_nettype wire

// ==== source/zx_ctl_top.sv ====
`default_nettype none

module zx_ctl_top #(
    parameter logic [8:0] h_max = 9'd447,
    parameter logic [8:0] v_max = 9'd319
) (
    input  wire fclk,
    input  wire rst_n,
    input  wire spick,
    input  wire spics_n,
    input  wire spido,
    output wire spidi,
    output wire spiint_n,
    output wire beep,
    output wire vhsync,
    output wire vvsync,
    output wire vcsync
);

    // link side
    wire zx_ctl_pkg::byte_t cmd;
    wire zx_ctl_pkg::byte_t wr_data;
    wire zx_ctl_pkg::byte_t rd_data;
    wire                    frame_start;
    wire                    frame_end;

    // control registers and status
    wire zx_ctl_pkg::byte_t covox;
    wire                    tv_mode;
    wire                    covox_tick;
    wire                    vblank;

    spi_slave i_spi_slave (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .spick       (spick),
        .spics_n     (spics_n),
        .spido       (spido),
        .rd_data     (rd_data),
        .spidi       (spidi),
        .cmd         (cmd),
        .wr_data     (wr_data),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    avr_ctrl i_avr_ctrl (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .wr_data     (wr_data),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .covox_tick  (covox_tick),
        .vblank      (vblank),
        .rd_data     (rd_data),
        .covox       (covox),
        .tv_mode     (tv_mode),
        .spiint_n    (spiint_n)
    );

    covox_pwm i_covox_pwm (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .covox       (covox),
        .beep        (beep),
        .covox_tick  (covox_tick)
    );

    video_timing #(
        .h_max (h_max),
        .v_max (v_max)
    ) i_video_timing (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .tv_mode     (tv_mode),
        .hsync       (vhsync),
        .vsync       (vvsync),
        .vcsync      (vcsync),
        .vblank      (vblank)
    );

endmodule

`default_nettype wire

// ==== test/zx_ctl_chk.sv ====
`default_nettype none

module zx_ctl_chk (
    input wire                          fclk,
    input wire                          rst_n,
    input wire                          spiint_n,
    input wire                          frame_end,
    input wire                          vsync,
    input wire zx_ctl_pkg::link_phase_e phase,
    input wire [8:0]                    vcount
);

    // interrupt line quiet through reset and the cycle after
    a_int_reset: assert property (@(posedge fclk) !rst_n |=> spiint_n)
        else $error("spiint_n low during or right after reset");

    // frame end only straight out of a data phase
    a_frame_phase: assert property (@(posedge fclk) disable iff (!rst_n)
        frame_end |-> ($past(phase) == zx_ctl_pkg::data_phase))
        else $error("frame_end without a data phase before it");

    // vsync only on vertical counts 0 and 1
    a_vsync_lines: assert property (@(posedge fclk) disable iff (!rst_n)
        (vcount > 9'd1) |-> !vsync)
        else $error("vsync high outside its lines");

endmodule

bind zx_ctl_top zx_ctl_chk i_zx_ctl_chk (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .spiint_n  (spiint_n),
    .frame_end (frame_end),
    .vsync     (vvsync),
    .phase     (i_spi_slave.phase),
    .vcount    (i_video_timing.vcount)
);

`default_nettype wire

// ==== test/tb_top.sv ====
`default_nettype none

module tb_top;

    localparam logic [8:0] h_max = 9'd447;
    localparam logic [8:0] v_max = 9'd319;

    // expected spacings from the raster rules
    localparam int line_tv      = (int'(h_max) + 1) * 4;
    localparam int line_vga     = (int'(h_max) + 1) * 2;
    localparam int frame_cycles = (int'(h_max) + 1) * (int'(v_max) + 1) * 4;

    // two frame-spacing runs of up to two frames each plus link traffic
    localparam int timeout_cycles = 2500000;

    logic fclk;
    logic rst_n;
    logic spick;
    logic spics_n;
    logic spido;
    wire  spidi;
    wire  spiint_n;
    wire  beep;
    wire  vhsync;
    wire  vvsync;
    wire  vcsync;

    int cycle = 0;

    // edge monitor state
    logic hs_q   = 1'b1;
    logic vs_q   = 1'b1;
    logic int_q  = 1'b1;
    int hs_cnt     = 0;
    int hs_last    = 0;
    int hs_period  = 0;
    int vs_cnt     = 0;
    int vs_last    = 0;
    int vs_period  = 0;
    int int_cnt    = 0;
    int int_last   = 0;
    int int_period = 0;

    zx_ctl_pkg::byte_t covox_model = zx_ctl_pkg::covox_reset;

    zx_ctl_top #(
        .h_max (h_max),
        .v_max (v_max)
    ) i_dut (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .spick    (spick),
        .spics_n  (spics_n),
        .spido    (spido),
        .spidi    (spidi),
        .spiint_n (spiint_n),
        .beep     (beep),
        .vhsync   (vhsync),
        .vvsync   (vvsync),
        .vcsync   (vcsync)
    );

    initial
        fclk = 1'b0;

    always #4 fclk = ~fclk;

    // --------------------
    // reporting
    // --------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input zx_ctl_pkg::byte_t got,
                              input zx_ctl_pkg::byte_t exp);
        if (got !== exp)
            abort_run($sformatf("error at time %0t: %s is 8'h%02h, expected 8'h%02h",
                                $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("error at time %0t: %s is %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    always @(posedge fclk)
    begin
        cycle = cycle + 1;
        if (cycle >= timeout_cycles)
            abort_run($sformatf("timeout after %0d cycles, the tests did not finish", cycle));
    end

    // rising sync edges and falling interrupt edges sampled mid-cycle
    always @(negedge fclk)
    begin
        if (vhsync && !hs_q)
        begin
            hs_period = cycle - hs_last;
            hs_last   = cycle;
            hs_cnt    = hs_cnt + 1;
        end
        if (vvsync && !vs_q)
        begin
            vs_period = cycle - vs_last;
            vs_last   = cycle;
            vs_cnt    = vs_cnt + 1;
        end
        if (!spiint_n && int_q)
        begin
            int_period = cycle - int_last;
            int_last   = cycle;
            int_cnt    = int_cnt + 1;
        end
        hs_q  = vhsync;
        vs_q  = vvsync;
        int_q = spiint_n;
    end

    // --------------------
    // drivers
    // --------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge fclk);
        #1;
    endtask

    // spick idles low and spends 4 fclk low and 4 high per bit
    task automatic spi_xfer(input zx_ctl_pkg::byte_t cmd_byte,
                            input zx_ctl_pkg::byte_t data_byte,
                            output zx_ctl_pkg::byte_t rd_byte);
        int i;
        for (i = 7; i >= 0; i--)
        begin
            spido = cmd_byte[i];
            wait_cycles(4);
            spick = 1'b1;
            wait_cycles(4);
            spick = 1'b0;
        end
        wait_cycles(4);
        spics_n = 1'b0;
        wait_cycles(8);
        for (i = 7; i >= 0; i--)
        begin
            spido = data_byte[i];
            wait_cycles(4);
            rd_byte[i] = spidi;
            spick = 1'b1;
            wait_cycles(4);
            spick = 1'b0;
        end
        wait_cycles(4);
        spics_n = 1'b1;
        wait_cycles(8);
    endtask

    task automatic count_beep_high(input int n, output int hi);
        int k;
        hi = 0;
        for (k = 0; k < n; k++)
        begin
            @(negedge fclk);
            if (beep)
                hi++;
        end
        wait_cycles(1);
    endtask

    task automatic count_int_low(input int n, output int lo);
        int k;
        lo = 0;
        for (k = 0; k < n; k++)
        begin
            @(negedge fclk);
            if (!spiint_n)
                lo++;
        end
        wait_cycles(1);
    endtask

    task automatic measure_hsync(input int exp_period);
        int start;
        start = hs_cnt;
        while (hs_cnt < start + 2)
            @(posedge fclk);
        #1;
        check_count("vhsync period", hs_period, exp_period);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_covox_readback();
        zx_ctl_pkg::byte_t rd;
        spi_xfer(zx_ctl_pkg::cmd_covox, 8'h3c, rd);
        check_byte("readback after reset", rd, ~zx_ctl_pkg::covox_reset);
        spi_xfer(zx_ctl_pkg::cmd_covox, 8'hc5, rd);
        check_byte("covox readback", rd, ~8'h3c);
        spi_xfer(zx_ctl_pkg::cmd_covox, 8'hc5, rd);
        check_byte("covox readback", rd, ~8'hc5);
        covox_model = 8'hc5;
    endtask

    // codes next to real ones with data that would flip the enables and mode
    task automatic test_unknown_cmd();
        zx_ctl_pkg::byte_t rd;
        int lo;
        spi_xfer(8'h00, 8'h03, rd);
        check_byte("unknown command readback", rd, zx_ctl_pkg::read_idle);
        spi_xfer(8'hae, 8'h00, rd);
        check_byte("unknown command readback", rd, zx_ctl_pkg::read_idle);
        count_int_low(1100, lo);
        check_count("spiint_n low cycles", lo, 0);
        spi_xfer(zx_ctl_pkg::cmd_covox, covox_model, rd);
        check_byte("covox readback", rd, ~covox_model);
    endtask

    task automatic test_beep_duty();
        zx_ctl_pkg::byte_t rd;
        zx_ctl_pkg::byte_t vals [3];
        int hi;
        int i;
        vals[0] = 8'h00;
        vals[1] = 8'h7f;
        vals[2] = 8'hff;
        for (i = 0; i < 3; i++)
        begin
            spi_xfer(zx_ctl_pkg::cmd_covox, vals[i], rd);
            covox_model = vals[i];
            // let the old sample drain out of the window
            wait_cycles(300);
            count_beep_high(512, hi);
            check_count("beep high cycles", hi, 2 * int'(vals[i]));
        end
    endtask

    task automatic test_covox_int();
        zx_ctl_pkg::byte_t rd;
        int lo;
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h00, rd);
        count_int_low(4096, lo);
        check_count("spiint_n low cycles", lo, 0);
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h01, rd);
        count_int_low(4096, lo);
        // 4 tick cycles per 1024
        check_count("spiint_n low cycles", lo, (4096 / 1024) * 4);
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h00, rd);
    endtask

    // tv composite sync outside the vsync lines is up for the hsync steps only
    task automatic test_csync_tv();
        int lo;
        int k;
        @(posedge vhsync);
        @(negedge fclk);
        lo = 0;
        for (k = 0; k < line_tv; k++)
        begin
            if (!vcsync)
                lo++;
            @(negedge fclk);
        end
        wait_cycles(1);
        check_count("vcsync low cycles", lo, int'(zx_ctl_pkg::hsync_end_tv) * 4);
    endtask

    task automatic test_frame_int();
        zx_ctl_pkg::byte_t rd;
        int vs0;
        int int0;
        int lo;
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h02, rd);
        vs0  = vs_cnt;
        int0 = int_cnt;
        while ((vs_cnt < vs0 + 2) || (int_cnt < int0 + 2))
            @(posedge fclk);
        #1;
        check_count("vvsync period", vs_period, frame_cycles);
        check_count("spiint_n fall period", int_period, frame_cycles);
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h03, rd);
        count_int_low(4096, lo);
        check_count("spiint_n low cycles", lo, (4096 / 1024) * 4);
        spi_xfer(zx_ctl_pkg::cmd_int_control, 8'h00, rd);
    endtask

    task automatic test_vga_timing();
        zx_ctl_pkg::byte_t rd;
        int vs0;
        spi_xfer(zx_ctl_pkg::cmd_scr_mode, 8'h00, rd);
        measure_hsync(line_vga);
        vs0 = vs_cnt;
        while (vs_cnt < vs0 + 2)
            @(posedge fclk);
        #1;
        check_count("vvsync period", vs_period, frame_cycles);
    endtask

    initial
    begin
        rst_n   = 1'b0;
        spick   = 1'b0;
        spics_n = 1'b1;
        spido   = 1'b0;
        wait_cycles(10);
        rst_n = 1'b1;
        wait_cycles(4);

        test_covox_readback();
        test_unknown_cmd();
        test_beep_duty();
        test_covox_int();
        // still in tv mode after reset and the unknown codes
        measure_hsync(line_tv);
        test_csync_tv();
        test_frame_int();
        test_vga_timing();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== zx_ctl.f ====
common/zx_ctl_pkg.sv
source/spi_slave.sv
source/avr_ctrl.sv
source/covox_pwm.sv
video/video_timing.sv
source/zx_ctl_top.sv
test/zx_ctl_chk.sv
test/tb_top.sv

// ==== Makefile ====
# Verilator flow for zx_ctl

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= zx_ctl.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator's exit status is the test result
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
